// ==== Makefile ====
TOP = alu_cluster_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f sim.f

# the log decides, not the exit status of the simulation
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/alu_cluster.sv ====
`timescale 1ns/1ps

module alu_cluster (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        flush,

	input  logic                  [1:0] dispatch_taken,
	input  alu_pkg::dispatch_t    [1:0] dispatch,
	output logic                  [1:0] slot_ready,
	output alu_pkg::rs_index_t    [1:0] slot_index,

	input  alu_pkg::cdb_packet_t        ext_cdb,
	output alu_pkg::cdb_packet_t        cdb
);
	import alu_pkg::*;

	logic [RS_SIZE-1:0] issuable;
	logic               issue_valid;
	rs_index_t          issue_index;
	rs_entry_t          issue_entry;

	// own result bus loops back for wakeup
	alu_rs alu_rs_inst (
		.clk            ( clk            ),
		.rst_n          ( rst_n          ),
		.flush          ( flush          ),
		.dispatch_taken ( dispatch_taken ),
		.dispatch       ( dispatch       ),
		.slot_ready     ( slot_ready     ),
		.slot_index     ( slot_index     ),
		.cdb            ( cdb            ),
		.ext_cdb        ( ext_cdb        ),
		.issuable       ( issuable       ),
		.issue_valid    ( issue_valid    ),
		.issue_index    ( issue_index    ),
		.issue_entry    ( issue_entry    )
	);

	issue_select issue_select_inst (
		.clk         ( clk         ),
		.rst_n       ( rst_n       ),
		.flush       ( flush       ),
		.issuable    ( issuable    ),
		.issue_valid ( issue_valid ),
		.issue_index ( issue_index )
	);

	alu_exec alu_exec_inst (
		.clk         ( clk         ),
		.rst_n       ( rst_n       ),
		.flush       ( flush       ),
		.issue_valid ( issue_valid ),
		.issue_entry ( issue_entry ),
		.cdb         ( cdb         )
	);

endmodule

// ==== design/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush,

	input  logic                  issue_valid,
	input  alu_pkg::rs_entry_t    issue_entry,

	output alu_pkg::cdb_packet_t  cdb
);
	import alu_pkg::*;

	word_t                a;
	word_t                b;
	logic [SHAMT_W-1:0]   shamt;
	word_t                result;

	logic                 cdb_valid_q;
	tag_t                 cdb_tag_q;
	word_t                cdb_value_q;

	assign a     = issue_entry.src[0].value;
	assign b     = issue_entry.src[1].value;
	assign shamt = b[SHAMT_W-1:0];

	always_comb begin
		unique case (issue_entry.op)
			op_add: result = a + b;
			op_sub: result = a - b;
			op_and: result = a & b;
			op_or:  result = a | b;
			op_xor: result = a ^ b;
			op_sll: result = a << shamt;
			// logical shift with zero fill
			op_srl: result = a >> shamt;
			op_slt: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

	// one pulse per issue and none after flush
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			cdb_valid_q <= 1'b0;
		end else begin
			cdb_valid_q <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			cdb_tag_q   <= issue_entry.dest_tag;
			cdb_value_q <= result;
		end
	end

	assign cdb.valid = cdb_valid_q;
	assign cdb.tag   = cdb_tag_q;
	assign cdb.value = cdb_value_q;

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

	// station and datapath sizes
	localparam int RS_SIZE = 4;
	localparam int TAG_W   = 3;
	localparam int XLEN    = 32;

	// shift amount taken from the low bits of the second operand
	localparam int SHAMT_W = 5;

	typedef logic [$clog2(RS_SIZE)-1:0] rs_index_t;
	typedef logic [TAG_W-1:0]           tag_t;
	typedef logic [XLEN-1:0]            word_t;

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_sll,
		op_srl,
		op_slt
	} alu_op_t;

	// value when ready, otherwise tag of the producer still awaited
	typedef struct packed {
		logic  ready;
		tag_t  tag;
		word_t value;
	} operand_t;

	// one instruction as handed over by a dispatch lane
	typedef struct packed {
		alu_op_t        op;
		operand_t [1:0] src;
		tag_t           dest_tag;
	} dispatch_t;

	// station slot with the dispatch fields plus occupancy
	typedef struct packed {
		logic           busy;
		alu_op_t        op;
		operand_t [1:0] src;
		tag_t           dest_tag;
	} rs_entry_t;

	// result broadcast
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t value;
	} cdb_packet_t;

endpackage

// ==== design/alu_rs.sv ====
`timescale 1ns/1ps

module alu_rs (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          flush,

	// dispatch lanes
	input  logic                    [1:0] dispatch_taken,
	input  alu_pkg::dispatch_t      [1:0] dispatch,
	output logic                    [1:0] slot_ready,
	output alu_pkg::rs_index_t      [1:0] slot_index,

	// result buses
	input  alu_pkg::cdb_packet_t          cdb,
	input  alu_pkg::cdb_packet_t          ext_cdb,

	// issue side
	output logic  [alu_pkg::RS_SIZE-1:0]  issuable,
	input  logic                          issue_valid,
	input  alu_pkg::rs_index_t            issue_index,
	output alu_pkg::rs_entry_t            issue_entry
);
	import alu_pkg::*;

	rs_entry_t [RS_SIZE-1:0] rs_q;
	rs_entry_t [RS_SIZE-1:0] rs_n;

	logic      [1:0] slot_ready_q;
	logic      [1:0] slot_ready_n;
	rs_index_t [1:0] slot_index_q;
	rs_index_t [1:0] slot_index_n;

	assign slot_ready  = slot_ready_q;
	assign slot_index  = slot_index_q;
	assign issue_entry = rs_q[issue_index];

	// capture a broadcast value for a waiting operand
	function automatic operand_t wake(operand_t opnd, cdb_packet_t own, cdb_packet_t ext);
		operand_t res;
		res = opnd;
		if (!opnd.ready && own.valid && own.tag == opnd.tag) begin
			res.ready = 1'b1;
			res.value = own.value;
		end else if (!opnd.ready && ext.valid && ext.tag == opnd.tag) begin
			res.ready = 1'b1;
			res.value = ext.value;
		end
		return res;
	endfunction

	// ready to go when both sources are known
	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			issuable[i] = rs_q[i].busy && rs_q[i].src[0].ready && rs_q[i].src[1].ready;
		end
	end

	// wakeup, then free, then dispatch writes
	always_comb begin
		rs_n = rs_q;

		for (int i = 0; i < RS_SIZE; i++) begin
			for (int s = 0; s < 2; s++) begin
				rs_n[i].src[s] = wake(rs_q[i].src[s], cdb, ext_cdb);
			end
		end

		if (issue_valid) begin
			rs_n[issue_index].busy = 1'b0;
		end

		// a source broadcast in this very cycle lands as ready
		for (int l = 0; l < 2; l++) begin
			if (dispatch_taken[l]) begin
				rs_n[slot_index_q[l]].busy     = 1'b1;
				rs_n[slot_index_q[l]].op       = dispatch[l].op;
				rs_n[slot_index_q[l]].dest_tag = dispatch[l].dest_tag;
				for (int s = 0; s < 2; s++) begin
					rs_n[slot_index_q[l]].src[s] = wake(dispatch[l].src[s], cdb, ext_cdb);
				end
			end
		end
	end

	// slot offers from next occupancy with the highest free index first
	always_comb begin
		slot_ready_n = '0;
		slot_index_n = '0;

		for (int i = 0; i < RS_SIZE; i++) begin
			if (!rs_n[i].busy) begin
				slot_ready_n[0] = 1'b1;
				slot_index_n[0] = rs_index_t'(i);
			end
		end

		for (int i = 0; i < RS_SIZE; i++) begin
			if (!rs_n[i].busy && slot_index_n[0] != rs_index_t'(i)) begin
				slot_ready_n[1] = 1'b1;
				slot_index_n[1] = rs_index_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		rs_q <= rs_n;
		if (!rst_n || flush) begin
			for (int i = 0; i < RS_SIZE; i++) begin
				rs_q[i].busy <= 1'b0;
			end
			slot_ready_q    <= 2'b11;
			slot_index_q[0] <= rs_index_t'(RS_SIZE - 1);
			slot_index_q[1] <= rs_index_t'(RS_SIZE - 2);
		end else begin
			slot_ready_q <= slot_ready_n;
			slot_index_q <= slot_index_n;
		end
	end

endmodule

// ==== design/issue_select.sv ====
`timescale 1ns/1ps

module issue_select (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,

	input  logic [alu_pkg::RS_SIZE-1:0]  issuable,
	output logic                         issue_valid,
	output alu_pkg::rs_index_t           issue_index
);
	import alu_pkg::*;

	// round-robin pointer where the search starts
	rs_index_t rr_ptr;

	// first issuable entry at or after the pointer
	always_comb begin
		rs_index_t cand;

		cand        = rr_ptr;
		issue_valid = 1'b0;
		issue_index = rr_ptr;

		// walk offsets backwards so the nearest hit is kept last
		for (int k = RS_SIZE - 1; k >= 0; k--) begin
			cand = rr_ptr + rs_index_t'(k);
			if (issuable[cand]) begin
				issue_valid = 1'b1;
				issue_index = cand;
			end
		end
	end

	// move past the winner so every ready entry gets a turn
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			rr_ptr <= '0;
		end else if (issue_valid) begin
			rr_ptr <= issue_index + rs_index_t'(1);
		end
	end

endmodule

// ==== sim.f ====
design/alu_pkg.sv
design/issue_select.sv
design/alu_exec.sv
design/alu_rs.sv
design/alu_cluster.sv
verification/alu_cluster_tb.sv

// ==== verification/alu_cluster_tb.sv ====
`timescale 1ns/1ps

module alu_cluster_tb;
	import alu_pkg::*;

	localparam logic [31:0] SEED  = 32'd87;
	localparam int N_RANDOM       = 100;
	localparam int N_PRE_FLUSH    = 8;
	localparam int N_AFTER_FLUSH  = 40;
	localparam int N_INSTR        = N_RANDOM + RS_SIZE + N_PRE_FLUSH + N_AFTER_FLUSH;
	localparam int TIMEOUT_CYCLES = 40 * N_INSTR + 200;
	// tags 0..5 belong to the cluster, 6 and 7 to the external bus
	localparam int CLUSTER_TAGS   = 6;

	logic                 clk;
	logic                 rst_n;
	logic                 flush;
	logic           [1:0] dispatch_taken;
	dispatch_t      [1:0] dispatch;
	logic           [1:0] slot_ready;
	rs_index_t      [1:0] slot_index;
	cdb_packet_t          ext_cdb;
	cdb_packet_t          cdb;

	// reference model indexed by destination tag
	bit        outstanding [8];
	alu_op_t   op_m        [8];
	bit        src_known   [8][2];
	word_t     src_val     [8][2];
	tag_t      src_tag     [8][2];
	bit        ext_pending [8];
	bit        occ_busy    [RS_SIZE];
	tag_t      occ_tag     [RS_SIZE];

	bit          just_seen;
	tag_t        just_tag;
	word_t       just_val;
	bit          hold_ext;
	bit          wait_ext_only;
	int          budget;
	logic [31:0] rng_state;
	int          mismatch_count;
	int          other_count;
	int          dispatched;
	int          results;
	int          cancelled;
	int          cycle_count;

	alu_cluster alu_cluster_inst (
		.clk            ( clk            ),
		.rst_n          ( rst_n          ),
		.flush          ( flush          ),
		.dispatch_taken ( dispatch_taken ),
		.dispatch       ( dispatch       ),
		.slot_ready     ( slot_ready     ),
		.slot_index     ( slot_index     ),
		.ext_cdb        ( ext_cdb        ),
		.cdb            ( cdb            )
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d results still outstanding",
				cycle_count, outstanding_count());
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) flush |=> !cdb.valid)
		else begin
			mismatch_count++;
			$display("Mismatch at %0t: cdb.valid after flush expected 0 got 1", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(&slot_ready) |-> (slot_index[0] != slot_index[1]))
		else begin
			other_count++;
			$display("%0t: both lanes offer the same entry %0d", $time, slot_index[0]);
		end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_t model_result(alu_op_t op, word_t a, word_t b);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_sll:  return a << b[4:0];
			op_srl:  return a >> b[4:0];
			op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic int outstanding_count();
		int n;
		n = 0;
		for (int t = 0; t < 8; t++) begin
			if (outstanding[t]) n++;
		end
		return n;
	endfunction

	function automatic int busy_count();
		int n;
		n = 0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (occ_busy[i]) n++;
		end
		return n;
	endfunction

	// wake model operands waiting on this tag
	task automatic broadcast_update(input tag_t tag, input word_t value);
		for (int t = 0; t < 8; t++) begin
			for (int s = 0; s < 2; s++) begin
				if (outstanding[t] && !src_known[t][s] && src_tag[t][s] == tag) begin
					src_known[t][s] = 1'b1;
					src_val[t][s]   = value;
				end
			end
		end
	endtask

	task automatic observe_cdb();
		tag_t  t;
		word_t expected;
		just_seen = 1'b0;
		if (cdb.valid) begin
			t = cdb.tag;
			results++;
			assert (outstanding[t]) else begin
				other_count++;
				$display("%0t: cdb carries tag %0d with nothing outstanding", $time, t);
			end
			if (outstanding[t]) begin
				assert (src_known[t][0] && src_known[t][1]) else begin
					other_count++;
					$display("%0t: tag %0d issued before both operands arrived", $time, t);
				end
				if (src_known[t][0] && src_known[t][1]) begin
					expected = model_result(op_m[t], src_val[t][0], src_val[t][1]);
					assert (cdb.value == expected) else begin
						mismatch_count++;
						$display("Mismatch at %0t: cdb.value tag %0d (%s) expected %08h got %08h",
							$time, t, op_m[t].name(), expected, cdb.value);
					end
				end
				outstanding[t] = 1'b0;
				for (int i = 0; i < RS_SIZE; i++) begin
					if (occ_busy[i] && occ_tag[i] == t) occ_busy[i] = 1'b0;
				end
			end
			broadcast_update(t, cdb.value);
			just_seen = 1'b1;
			just_tag  = t;
			just_val  = cdb.value;
		end
	endtask

	task automatic check_offers();
		int         free_n;
		logic [1:0] exp_ready;
		free_n    = RS_SIZE - busy_count();
		exp_ready = {free_n >= 2, free_n >= 1};
		assert (slot_ready == exp_ready) else begin
			mismatch_count++;
			$display("Mismatch at %0t: slot_ready expected %b got %b", $time, exp_ready, slot_ready);
		end
		for (int l = 0; l < 2; l++) begin
			if (slot_ready[l]) begin
				assert (!occ_busy[slot_index[l]]) else begin
					other_count++;
					$display("%0t: lane %0d offers occupied entry %0d", $time, l, slot_index[l]);
				end
			end
		end
	endtask

	// state expected right after reset or flush
	task automatic check_cleared();
		assert (cdb.valid == 1'b0) else begin
			mismatch_count++;
			$display("Mismatch at %0t: cdb.valid expected 0 got %b", $time, cdb.valid);
		end
		assert (slot_ready == 2'b11) else begin
			mismatch_count++;
			$display("Mismatch at %0t: slot_ready expected 11 got %b", $time, slot_ready);
		end
		assert (slot_index[0] == rs_index_t'(3) && slot_index[1] == rs_index_t'(2)) else begin
			mismatch_count++;
			$display("Mismatch at %0t: slot_index expected 3,2 got %0d,%0d",
				$time, slot_index[0], slot_index[1]);
		end
	endtask

	task automatic drive_ext();
		logic [31:0] r;
		tag_t        e;
		r = next_rand();
		e = r[4] ? tag_t'(7) : tag_t'(6);
		if (!hold_ext && ext_pending[e] && r[1:0] == 2'd0) begin
			ext_cdb.valid  = 1'b1;
			ext_cdb.tag    = e;
			ext_cdb.value  = next_rand();
			ext_pending[e] = 1'b0;
			broadcast_update(e, ext_cdb.value);
		end
	endtask

	// ready value, own producer, producer on cdb right now, or external tag
	task automatic make_source(output operand_t o, output bit known, output word_t val);
		logic [31:0] r;
		tag_t        t;
		int          pick;
		r     = next_rand();
		o     = '0;
		known = 1'b0;
		val   = '0;
		pick  = -1;
		if (!wait_ext_only && r[1:0] == 2'd1) begin
			for (int k = 0; k < CLUSTER_TAGS; k++) begin
				t = tag_t'((int'(r[10:8]) + k) % CLUSTER_TAGS);
				if (outstanding[t] && !(just_seen && t == just_tag)) pick = int'(t);
			end
		end
		if (!wait_ext_only && r[2:0] == 3'd0 && just_seen) begin
			o.tag = just_tag;
			known = 1'b1;
			val   = just_val;
		end else if (pick >= 0) begin
			o.tag = tag_t'(pick);
		end else if (wait_ext_only || r[2:0] == 3'd2) begin
			o.tag = r[3] ? tag_t'(7) : tag_t'(6);
			if (ext_cdb.valid && ext_cdb.tag == o.tag) begin
				known = 1'b1;
				val   = ext_cdb.value;
			end else begin
				ext_pending[o.tag] = 1'b1;
			end
		end else begin
			val     = next_rand();
			o.ready = 1'b1;
			o.value = val;
			known   = 1'b1;
		end
	endtask

	task automatic drive_dispatch(input bit enable);
		dispatch_t   d;
		operand_t    o     [2];
		bit          known [2];
		word_t       v     [2];
		logic [31:0] r;
		tag_t        t;
		int          free_tag;
		for (int l = 0; l < 2; l++) begin
			r        = next_rand();
			free_tag = -1;
			for (int k = 0; k < CLUSTER_TAGS; k++) begin
				t = tag_t'((int'(r[6:4]) + k) % CLUSTER_TAGS);
				if (!outstanding[t]) free_tag = int'(t);
			end
			if (enable && budget > 0 && slot_ready[l] && r[1:0] != 2'd0 && free_tag >= 0) begin
				t    = tag_t'(free_tag);
				d.op = alu_op_t'(r[10:8]);
				for (int s = 0; s < 2; s++) begin
					make_source(o[s], known[s], v[s]);
					d.src[s]        = o[s];
					src_known[t][s] = known[s];
					src_val[t][s]   = v[s];
					src_tag[t][s]   = o[s].tag;
				end
				d.dest_tag        = t;
				dispatch[l]       = d;
				dispatch_taken[l] = 1'b1;
				outstanding[t]    = 1'b1;
				op_m[t]           = d.op;
				occ_busy[slot_index[l]] = 1'b1;
				occ_tag[slot_index[l]]  = t;
				dispatched++;
				budget--;
			end
		end
	endtask

	task automatic tick(input bit enable);
		@(negedge clk);
		dispatch_taken = '0;
		ext_cdb        = '0;
		observe_cdb();
		check_offers();
		drive_ext();
		drive_dispatch(enable);
	endtask

	task automatic drain();
		while (outstanding_count() != 0) tick(1'b0);
	endtask

	task automatic do_flush();
		tick(1'b0);
		@(negedge clk);
		dispatch_taken = '0;
		ext_cdb        = '0;
		flush          = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int t = 0; t < 8; t++) begin
			if (outstanding[t]) cancelled++;
			outstanding[t] = 1'b0;
			ext_pending[t] = 1'b0;
		end
		for (int i = 0; i < RS_SIZE; i++) occ_busy[i] = 1'b0;
		just_seen = 1'b0;
		check_cleared();
		repeat (3) begin
			tick(1'b0);
			check_cleared();
		end
	endtask

	initial begin
		rng_state      = SEED;
		rst_n          = 1'b0;
		flush          = 1'b0;
		dispatch_taken = '0;
		dispatch       = '0;
		ext_cdb        = '0;
		hold_ext       = 1'b0;
		wait_ext_only  = 1'b0;
		just_seen      = 1'b0;
		budget         = 0;
		mismatch_count = 0;
		other_count    = 0;
		dispatched     = 0;
		results        = 0;
		cancelled      = 0;
		cycle_count    = 0;
		for (int t = 0; t < 8; t++) begin
			outstanding[t] = 1'b0;
			ext_pending[t] = 1'b0;
		end
		for (int i = 0; i < RS_SIZE; i++) occ_busy[i] = 1'b0;

		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		check_cleared();

		// random mix with chains and external waits
		budget = N_RANDOM;
		while (budget > 0) tick(1'b1);
		drain();

		// fill the station behind held external tags
		hold_ext      = 1'b1;
		wait_ext_only = 1'b1;
		budget        = RS_SIZE;
		while (busy_count() < RS_SIZE) tick(1'b1);
		repeat (4) tick(1'b0);
		hold_ext      = 1'b0;
		wait_ext_only = 1'b0;
		drain();

		// flush with work in flight
		budget = N_PRE_FLUSH;
		repeat (6) tick(1'b1);
		do_flush();
		budget = N_AFTER_FLUSH;
		while (budget > 0) tick(1'b1);
		drain();

		assert (dispatched == results + cancelled) else begin
			other_count++;
			$display("%0d dispatched but %0d results and %0d cancelled",
				dispatched, results, cancelled);
		end

		$display("errors: %0d mismatches, %0d other failures (%0d dispatched, %0d results)",
			mismatch_count, other_count, dispatched, results);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
